// File: files.f
src/csr_pkg.sv
src/csr_write_select.sv
src/csr_exception_regs.sv
src/csr_timer.sv
src/csr_scratch_regs.sv
src/csr_read_mux.sv
src/csr_file.sv
tb/tb_clock_gen.sv
tb/csr_file_tb.sv

// File: Makefile
TOP = csr_file_tb

.PHONY: sim clean

sim:
	verilator --binary --timing -f files.f --top-module $(TOP)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "^RESULT: PASS$$"

clean:
	rm -rf obj_dir

// File: tb/csr_file_tb.sv
`timescale 1ns/10ps

module csr_file_tb
    import csr_pkg::*;
;

    localparam int ONESHOT_INIT = 3;
    localparam int ONESHOT_N    = 4 * ONESHOT_INIT;
    localparam int PERIODIC_INIT = 2;
    localparam int PERIODIC_N    = 4 * PERIODIC_INIT;
    localparam int RUN_CYCLES = 5 + 12 + 12 + 6 * 4
                                + (ONESHOT_N + 1) + 3 * (PERIODIC_N + 1) + 16;
    localparam int WATCHDOG_NS = 10 * (RUN_CYCLES + 40);

    logic        clk;
    logic        rst;
    csr_write_t  wr1;
    csr_write_t  wr2;
    excp_event_t excp;
    va_fault_t   va_fault;
    logic [8:0]  interrupt_lines;
    csr_addr_t   raddr;
    csr_word_t   rdata;
    logic        has_int;
    logic [1:0]  plv;
    csr_word_t   eentry;
    csr_word_t   era;
    csr_word_t   tid;

    int error_count = 0;
    int check_count = 0;
    integer seed = 44345;

    tb_clock_gen clock_gen_inst (
        .clk_o (clk),
        .rst_o (rst)
    );

    csr_file #(
        .CPU_ID (32'h0000_0007)
    ) csr_file_inst (
        .clk         (clk),
        .rst         (rst),
        .wr1_i       (wr1),
        .wr2_i       (wr2),
        .excp_i      (excp),
        .va_fault_i  (va_fault),
        .interrupt_i (interrupt_lines),
        .raddr_i     (raddr),
        .rdata_o     (rdata),
        .has_int_o   (has_int),
        .plv_o       (plv),
        .eentry_o    (eentry),
        .era_o       (era),
        .tid_o       (tid)
    );

    task automatic check_value(input string name, input csr_word_t expected,
                               input csr_word_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED: %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic read_csr(input csr_addr_t addr, output csr_word_t value);
        raddr = addr;
        #0.2;
        value = rdata;
    endtask

    task automatic expect_csr(input string name, input csr_addr_t addr,
                              input csr_word_t expected);
        csr_word_t value;
        read_csr(addr, value);
        check_value(name, expected, value);
    endtask

    // one write on port 1, visible after the edge
    task automatic write_csr(input csr_addr_t addr, input csr_word_t data);
        wr1 = '{we: 1'b1, addr: addr, data: data};
        next_cycle();
        wr1.we = 1'b0;
    endtask

    // interrupt pending rule
    function automatic logic int_expected(input logic [12:0] ectl, input logic [12:0] is_bits,
                                          input logic ie);
        return (|(ectl & is_bits)) & ie;
    endfunction

    task automatic test_reset();
        expect_csr("reset crmd", CSR_CRMD, 32'h8);
        expect_csr("reset prmd", CSR_PRMD, 32'h0);
        expect_csr("reset ectl", CSR_ECTL, 32'h0);
        expect_csr("reset estat", CSR_ESTAT, 32'h0);
        expect_csr("reset tid", CSR_TID, 32'h0);
        expect_csr("reset cpuid", CSR_CPUID, 32'h7);
        expect_csr("reset unused address", 14'h100, 32'h0);
        check_value("reset has_int", 32'h0, {31'b0, has_int});
        check_value("reset plv", 32'h0, {30'b0, plv});
    endtask

    task automatic test_write_ports();
        csr_addr_t addrs[5] = '{CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3, CSR_TID};
        csr_word_t words[5];
        csr_word_t word_a;
        csr_word_t word_b;
        for (int i = 0; i < 5; i++) begin
            words[i] = $random(seed);
            write_csr(addrs[i], words[i]);
        end
        for (int i = 0; i < 5; i++) begin
            expect_csr("scratch readback", addrs[i], words[i]);
        end
        check_value("tid output", words[4], tid);
        // both ports in one cycle
        word_a = $random(seed);
        word_b = $random(seed);
        wr1 = '{we: 1'b1, addr: CSR_SAVE0, data: word_a};
        wr2 = '{we: 1'b1, addr: CSR_SAVE1, data: word_b};
        next_cycle();
        wr1.we = 1'b0;
        wr2.we = 1'b0;
        expect_csr("port 1 wins", CSR_SAVE0, word_a);
        expect_csr("port 2 dropped", CSR_SAVE1, words[1]);
        wr2 = '{we: 1'b1, addr: CSR_SAVE2, data: word_b};
        next_cycle();
        wr2.we = 1'b0;
        expect_csr("port 2 alone", CSR_SAVE2, word_b);
    endtask

    task automatic test_exception();
        csr_word_t excp_pc = 32'h1c00_1234;
        write_csr(CSR_CRMD, 32'hf);
        expect_csr("crmd before exception", CSR_CRMD, 32'hf);
        excp = '{excp_flush: 1'b1, ertn_flush: 1'b0, ecode: 6'h0b, esubcode: 9'h1a5,
                 era: excp_pc};
        #0.2;
        check_value("plv during exception", 32'h0, {30'b0, plv});
        next_cycle();
        excp.excp_flush = 1'b0;
        expect_csr("crmd after exception", CSR_CRMD, 32'h8);
        expect_csr("prmd after exception", CSR_PRMD, 32'h7);
        expect_csr("estat codes", CSR_ESTAT, {1'b0, 9'h1a5, 6'h0b, 16'h0});
        expect_csr("era after exception", CSR_ERA, excp_pc);
        check_value("era output", excp_pc, era);
        excp.ertn_flush = 1'b1;
        #0.2;
        check_value("plv during return", 32'h3, {30'b0, plv});
        next_cycle();
        excp.ertn_flush = 1'b0;
        expect_csr("crmd after return", CSR_CRMD, 32'hf);
        // write and fault on the same edge
        va_fault = '{valid: 1'b1, addr: 32'hdead_0040};
        write_csr(CSR_BADV, 32'h0000_beef);
        va_fault.valid = 1'b0;
        expect_csr("badv write wins", CSR_BADV, 32'h0000_beef);
        va_fault = '{valid: 1'b1, addr: 32'hdead_0040};
        next_cycle();
        va_fault.valid = 1'b0;
        expect_csr("badv fault", CSR_BADV, 32'hdead_0040);
        write_csr(CSR_EENTRY, 32'h1c00_0abc);
        check_value("eentry low bits", 32'h1c00_0a80, eentry);
    endtask

    task automatic int_case(input string name, input logic [12:0] ectl, input logic ie,
                            input logic [1:0] swi, input logic [8:0] lines);
        logic [12:0] is_bits;
        csr_word_t value;
        is_bits = {2'b00, lines, swi};
        interrupt_lines = lines;
        write_csr(CSR_ECTL, {19'b0, ectl});
        write_csr(CSR_CRMD, {28'b0, 1'b1, ie, 2'b00});
        write_csr(CSR_ESTAT, {30'b0, swi});
        read_csr(CSR_ESTAT, value);
        check_value(name, {19'b0, is_bits}, value & 32'h1fff);
        check_value(name, {31'b0, int_expected(ectl, is_bits, ie)}, {31'b0, has_int});
    endtask

    task automatic test_interrupts();
        int_case("int masked by ectl", 13'h000, 1'b1, 2'b00, 9'h155);
        int_case("int line enabled", 13'h010, 1'b1, 2'b00, 9'h155);
        int_case("int ie off", 13'h010, 1'b0, 2'b00, 9'h155);
        int_case("int software", 13'h001, 1'b1, 2'b01, 9'h000);
        int_case("int software masked", 13'h002, 1'b1, 2'b01, 9'h0aa);
        int_case("int random", 13'($random(seed)), 1'b1, 2'b10, 9'($random(seed)));
    endtask

    // counts edges until estat shows the timer flag
    task automatic wait_timer_flag(input int limit, output int cycles);
        csr_word_t value;
        cycles = 0;
        read_csr(CSR_ESTAT, value);
        while (!value[TIMER_IRQ_BIT] && cycles < limit) begin
            next_cycle();
            cycles++;
            read_csr(CSR_ESTAT, value);
        end
        if (!value[TIMER_IRQ_BIT]) begin
            error_count++;
            $display("timer flag did not set within %0d cycles", limit);
        end
    endtask

    task automatic test_timer();
        int cycles;
        csr_word_t value;
        interrupt_lines = '0;
        write_csr(CSR_ECTL, 32'h0);
        write_csr(CSR_ESTAT, 32'h0);
        write_csr(CSR_TCFG, {30'(ONESHOT_INIT), 2'b01});
        wait_timer_flag(4 * ONESHOT_N + 8, cycles);
        check_value("timer one-shot delay", ONESHOT_N + 1, cycles);
        expect_csr("timer stopped tval", CSR_TVAL, 32'hffff_ffff);
        next_cycle();
        next_cycle();
        read_csr(CSR_ESTAT, value);
        check_value("timer flag held", 32'h1, {31'b0, value[TIMER_IRQ_BIT]});
        write_csr(CSR_TICLR, 32'h1);
        read_csr(CSR_ESTAT, value);
        check_value("timer flag cleared", 32'h0, {31'b0, value[TIMER_IRQ_BIT]});
        expect_csr("ticlr reads zero", CSR_TICLR, 32'h0);
        // periodic, routed to has_int
        write_csr(CSR_ECTL, 32'h800);
        write_csr(CSR_CRMD, 32'hc);
        write_csr(CSR_TCFG, {30'(PERIODIC_INIT), 2'b11});
        wait_timer_flag(4 * PERIODIC_N + 8, cycles);
        check_value("timer periodic delay", PERIODIC_N + 1, cycles);
        check_value("timer has_int", 32'h1, {31'b0, has_int});
        write_csr(CSR_TICLR, 32'h1);
        check_value("timer has_int cleared", 32'h0, {31'b0, has_int});
        // the reload edge was one edge before the clear
        wait_timer_flag(4 * PERIODIC_N + 8, cycles);
        check_value("timer periodic again", PERIODIC_N + 1, cycles + 1);
        check_value("timer has_int again", 32'h1, {31'b0, has_int});
        write_csr(CSR_TCFG, 32'h0);
        write_csr(CSR_TICLR, 32'h1);
        // a disabled timer must not fire again
        repeat (PERIODIC_N + 2) next_cycle();
        read_csr(CSR_ESTAT, value);
        check_value("timer off flag", 32'h0, {31'b0, value[TIMER_IRQ_BIT]});
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: tests did not finish within %0d ns", WATCHDOG_NS);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        wr1 = '0;
        wr2 = '0;
        excp = '0;
        va_fault = '0;
        interrupt_lines = '0;
        raddr = '0;
        @(negedge rst);
        #1;
        test_reset();
        test_write_ports();
        test_exception();
        test_interrupts();
        test_timer();
        $display("checks: %0d  errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: tb/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // reset spans the first three rising edges
    initial begin
        rst_o = 1'b1;
        repeat (3) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

// File: src/csr_file.sv
`timescale 1ns/10ps

module csr_file
    import csr_pkg::*;
#(
    parameter csr_word_t CPU_ID = 32'h0
)
(
    input  logic        clk,
    input  logic        rst,
    input  csr_write_t  wr1_i,
    input  csr_write_t  wr2_i,
    input  excp_event_t excp_i,
    input  va_fault_t   va_fault_i,
    input  logic [8:0]  interrupt_i,
    input  csr_addr_t   raddr_i,
    output csr_word_t   rdata_o,
    output logic        has_int_o,
    output logic [1:0]  plv_o,
    output csr_word_t   eentry_o,
    output csr_word_t   era_o,
    output csr_word_t   tid_o
);

    csr_write_t    wr;
    logic          timer_irq;
    exc_view_t     exc_view;
    timer_view_t   timer_view;
    scratch_view_t scratch_view;

    csr_write_select csr_write_select_inst (
        .rst_i (rst),
        .wr1_i (wr1_i),
        .wr2_i (wr2_i),
        .wr_o  (wr)
    );

    csr_exception_regs csr_exception_regs_inst (
        .clk         (clk),
        .rst         (rst),
        .wr_i        (wr),
        .excp_i      (excp_i),
        .va_fault_i  (va_fault_i),
        .interrupt_i (interrupt_i),
        .timer_irq_i (timer_irq),
        .view_o      (exc_view),
        .has_int_o   (has_int_o),
        .plv_o       (plv_o),
        .eentry_o    (eentry_o),
        .era_o       (era_o)
    );

    csr_timer csr_timer_inst (
        .clk         (clk),
        .rst         (rst),
        .wr_i        (wr),
        .view_o      (timer_view),
        .timer_irq_o (timer_irq)
    );

    csr_scratch_regs csr_scratch_regs_inst (
        .clk    (clk),
        .rst    (rst),
        .wr_i   (wr),
        .view_o (scratch_view),
        .tid_o  (tid_o)
    );

    csr_read_mux #(
        .CPU_ID (CPU_ID)
    ) csr_read_mux_inst (
        .raddr_i   (raddr_i),
        .exc_i     (exc_view),
        .timer_i   (timer_view),
        .scratch_i (scratch_view),
        .rdata_o   (rdata_o)
    );

endmodule

// File: src/csr_read_mux.sv
`timescale 1ns/10ps

module csr_read_mux
    import csr_pkg::*;
#(
    parameter csr_word_t CPU_ID = 32'h0
)
(
    input  csr_addr_t     raddr_i,
    input  exc_view_t     exc_i,
    input  timer_view_t   timer_i,
    input  scratch_view_t scratch_i,
    output csr_word_t     rdata_o
);

    always_comb begin
        case (raddr_i)
            CSR_CRMD:   rdata_o = exc_i.crmd;
            CSR_PRMD:   rdata_o = exc_i.prmd;
            CSR_ECTL:   rdata_o = exc_i.ectl;
            CSR_ESTAT:  rdata_o = exc_i.estat;
            CSR_ERA:    rdata_o = exc_i.era;
            CSR_BADV:   rdata_o = exc_i.badv;
            CSR_EENTRY: rdata_o = exc_i.eentry;
            CSR_CPUID:  rdata_o = CPU_ID;
            CSR_SAVE0:  rdata_o = scratch_i.save0;
            CSR_SAVE1:  rdata_o = scratch_i.save1;
            CSR_SAVE2:  rdata_o = scratch_i.save2;
            CSR_SAVE3:  rdata_o = scratch_i.save3;
            CSR_TID:    rdata_o = scratch_i.tid;
            CSR_TCFG:   rdata_o = timer_i.tcfg;
            CSR_TVAL:   rdata_o = timer_i.tval;
            // ticlr is write-only and lands here too
            default:    rdata_o = '0;
        endcase
    end

endmodule

// File: src/csr_scratch_regs.sv
`timescale 1ns/10ps

module csr_scratch_regs
    import csr_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  csr_write_t    wr_i,
    output scratch_view_t view_o,
    output csr_word_t     tid_o
);

    csr_word_t save_q [4];
    csr_word_t tid_q;

    logic wr_save;
    logic wr_tid;

    // save0..save3 sit on four consecutive addresses
    assign wr_save = wr_i.we && (wr_i.addr[13:2] == CSR_SAVE0[13:2]);
    assign wr_tid  = wr_i.we && (wr_i.addr == CSR_TID);

    always_ff @(posedge clk) begin
        if (wr_save) begin
            save_q[wr_i.addr[1:0]] <= wr_i.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tid_q <= '0;
        end else if (wr_tid) begin
            tid_q <= wr_i.data;
        end
    end

    assign tid_o = tid_q;

    assign view_o = '{
        save0: save_q[0],
        save1: save_q[1],
        save2: save_q[2],
        save3: save_q[3],
        tid:   tid_q
    };

endmodule

// File: src/csr_timer.sv
`timescale 1ns/10ps

module csr_timer
    import csr_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  csr_write_t  wr_i,
    output timer_view_t view_o,
    output logic        timer_irq_o
);

    csr_word_t tcfg_q;
    csr_word_t tval_q;
    logic timer_en_q;
    logic irq_q;

    logic wr_tcfg;
    logic clr_irq;
    logic expire;
    csr_word_t load_val;
    csr_word_t reload_val;

    assign wr_tcfg = wr_i.we && (wr_i.addr == CSR_TCFG);
    assign clr_irq = wr_i.we && (wr_i.addr == CSR_TICLR) && wr_i.data[TICLR_CLR];
    assign expire  = timer_en_q && (tval_q == '0);

    // initval counts in units of four cycles
    assign load_val   = {wr_i.data[TCFG_INITVAL_MSB:TCFG_INITVAL_LSB], 2'b00};
    assign reload_val = {tcfg_q[TCFG_INITVAL_MSB:TCFG_INITVAL_LSB], 2'b00};

    always_ff @(posedge clk) begin
        if (rst) begin
            tcfg_q <= '0;
        end else if (wr_tcfg) begin
            tcfg_q <= wr_i.data;
        end
    end

    // one-shot mode stops after the first expiry
    always_ff @(posedge clk) begin
        if (rst) begin
            timer_en_q <= 1'b0;
        end else if (wr_tcfg) begin
            timer_en_q <= wr_i.data[TCFG_EN];
        end else if (expire) begin
            timer_en_q <= tcfg_q[TCFG_PERIODIC];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_tcfg) begin
            tval_q <= load_val;
        end else if (expire) begin
            tval_q <= tcfg_q[TCFG_PERIODIC] ? reload_val : '1;
        end else if (timer_en_q) begin
            tval_q <= tval_q - 32'd1;
        end
    end

    // clear beats tcfg write beats expiry
    always_ff @(posedge clk) begin
        if (rst) begin
            irq_q <= 1'b0;
        end else if (clr_irq) begin
            irq_q <= 1'b0;
        end else if (expire && !wr_tcfg) begin
            irq_q <= 1'b1;
        end
    end

    assign timer_irq_o = irq_q;

    assign view_o = '{
        tcfg: tcfg_q,
        tval: tval_q
    };

endmodule

// File: src/csr_exception_regs.sv
`timescale 1ns/10ps

module csr_exception_regs
    import csr_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  csr_write_t  wr_i,
    input  excp_event_t excp_i,
    input  va_fault_t   va_fault_i,
    input  logic [8:0]  interrupt_i,
    input  logic        timer_irq_i,
    output exc_view_t   view_o,
    output logic        has_int_o,
    output logic [1:0]  plv_o,
    output csr_word_t   eentry_o,
    output csr_word_t   era_o
);

    csr_word_t crmd_q;
    csr_word_t prmd_q;
    csr_word_t ectl_q;
    csr_word_t era_q;
    csr_word_t badv_q;
    logic [ESTAT_SWI_MSB:0] swi_q;
    logic [8:0] hwi_q;
    logic [5:0] ecode_q;
    logic [8:0] esubcode_q;
    logic [EENTRY_VA_MSB:EENTRY_VA_LSB] eentry_va_q;

    csr_word_t estat;
    csr_word_t eentry;

    logic wr_crmd;
    logic wr_prmd;
    logic wr_ectl;
    logic wr_estat;
    logic wr_era;
    logic wr_badv;
    logic wr_eentry;

    assign wr_crmd   = wr_i.we && (wr_i.addr == CSR_CRMD);
    assign wr_prmd   = wr_i.we && (wr_i.addr == CSR_PRMD);
    assign wr_ectl   = wr_i.we && (wr_i.addr == CSR_ECTL);
    assign wr_estat  = wr_i.we && (wr_i.addr == CSR_ESTAT);
    assign wr_era    = wr_i.we && (wr_i.addr == CSR_ERA);
    assign wr_badv   = wr_i.we && (wr_i.addr == CSR_BADV);
    assign wr_eentry = wr_i.we && (wr_i.addr == CSR_EENTRY);

    // crmd, flush and return override software writes
    always_ff @(posedge clk) begin
        if (rst) begin
            crmd_q <= '0;
            crmd_q[CRMD_DA] <= 1'b1;
        end else if (excp_i.excp_flush) begin
            crmd_q[CRMD_PLV_MSB:CRMD_PLV_LSB] <= 2'b00;
            crmd_q[CRMD_IE] <= 1'b0;
        end else if (excp_i.ertn_flush) begin
            crmd_q[CRMD_PLV_MSB:CRMD_PLV_LSB] <= prmd_q[PRMD_PPLV_MSB:PRMD_PPLV_LSB];
            crmd_q[CRMD_IE] <= prmd_q[PRMD_PIE];
        end else if (wr_crmd) begin
            crmd_q[CRMD_PLV_MSB:CRMD_PLV_LSB]   <= wr_i.data[CRMD_PLV_MSB:CRMD_PLV_LSB];
            crmd_q[CRMD_IE]                     <= wr_i.data[CRMD_IE];
            crmd_q[CRMD_DA]                     <= wr_i.data[CRMD_DA];
            crmd_q[CRMD_PG]                     <= wr_i.data[CRMD_PG];
            crmd_q[CRMD_DATF_MSB:CRMD_DATF_LSB] <= wr_i.data[CRMD_DATF_MSB:CRMD_DATF_LSB];
            crmd_q[CRMD_DATM_MSB:CRMD_DATM_LSB] <= wr_i.data[CRMD_DATM_MSB:CRMD_DATM_LSB];
        end
    end

    // prmd saves plv and ie on exception entry
    always_ff @(posedge clk) begin
        if (rst) begin
            prmd_q <= '0;
        end else if (excp_i.excp_flush) begin
            prmd_q[PRMD_PPLV_MSB:PRMD_PPLV_LSB] <= crmd_q[CRMD_PLV_MSB:CRMD_PLV_LSB];
            prmd_q[PRMD_PIE] <= crmd_q[CRMD_IE];
        end else if (wr_prmd) begin
            prmd_q[PRMD_PPLV_MSB:PRMD_PPLV_LSB] <= wr_i.data[PRMD_PPLV_MSB:PRMD_PPLV_LSB];
            prmd_q[PRMD_PIE] <= wr_i.data[PRMD_PIE];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ectl_q <= '0;
        end else if (wr_ectl) begin
            ectl_q[INT_MSB:INT_LSB] <= wr_i.data[INT_MSB:INT_LSB];
        end
    end

    // hardware lines are sampled every cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            swi_q      <= '0;
            hwi_q      <= '0;
            ecode_q    <= '0;
            esubcode_q <= '0;
        end else begin
            hwi_q <= interrupt_i;
            if (excp_i.excp_flush) begin
                ecode_q    <= excp_i.ecode;
                esubcode_q <= excp_i.esubcode;
            end else if (wr_estat) begin
                swi_q <= wr_i.data[ESTAT_SWI_MSB:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (excp_i.excp_flush) begin
            era_q <= excp_i.era;
        end else if (wr_era) begin
            era_q <= wr_i.data;
        end
    end

    // software write beats a faulting address
    always_ff @(posedge clk) begin
        if (wr_badv) begin
            badv_q <= wr_i.data;
        end else if (va_fault_i.valid) begin
            badv_q <= va_fault_i.addr;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_eentry) begin
            eentry_va_q <= wr_i.data[EENTRY_VA_MSB:EENTRY_VA_LSB];
        end
    end

    // timer flag joins estat without another register stage
    always_comb begin
        estat = '0;
        estat[ESTAT_SWI_MSB:0] = swi_q;
        estat[ESTAT_HWI_MSB:ESTAT_HWI_LSB] = hwi_q;
        estat[TIMER_IRQ_BIT] = timer_irq_i;
        estat[ESTAT_ECODE_MSB:ESTAT_ECODE_LSB] = ecode_q;
        estat[ESTAT_ESUBCODE_MSB:ESTAT_ESUBCODE_LSB] = esubcode_q;
    end

    assign eentry = {eentry_va_q, {EENTRY_VA_LSB{1'b0}}};

    assign has_int_o = (|(ectl_q[INT_MSB:INT_LSB] & estat[INT_MSB:INT_LSB])) & crmd_q[CRMD_IE];

    // privilege seen by the pipeline during a flush
    always_comb begin
        if (excp_i.excp_flush) begin
            plv_o = 2'b00;
        end else if (excp_i.ertn_flush) begin
            plv_o = prmd_q[PRMD_PPLV_MSB:PRMD_PPLV_LSB];
        end else begin
            plv_o = crmd_q[CRMD_PLV_MSB:CRMD_PLV_LSB];
        end
    end

    assign eentry_o = eentry;
    assign era_o    = era_q;

    assign view_o = '{
        crmd:   crmd_q,
        prmd:   prmd_q,
        ectl:   ectl_q,
        estat:  estat,
        era:    era_q,
        badv:   badv_q,
        eentry: eentry
    };

endmodule

// File: src/csr_write_select.sv
`timescale 1ns/10ps

module csr_write_select
    import csr_pkg::*;
(
    input  logic       rst_i,
    input  csr_write_t wr1_i,
    input  csr_write_t wr2_i,
    output csr_write_t wr_o
);

    // port 1 has priority, port 2 only lands when port 1 is idle
    always_comb begin
        if (wr1_i.we) begin
            wr_o = wr1_i;
        end else begin
            wr_o = wr2_i;
        end
        // no writes while in reset
        if (rst_i) begin
            wr_o.we = 1'b0;
        end
    end

endmodule

// File: src/csr_pkg.sv
package csr_pkg;

    typedef logic [13:0] csr_addr_t;
    typedef logic [31:0] csr_word_t;

    // register addresses
    localparam csr_addr_t CSR_CRMD   = 14'h0;
    localparam csr_addr_t CSR_PRMD   = 14'h1;
    localparam csr_addr_t CSR_ECTL   = 14'h4;
    localparam csr_addr_t CSR_ESTAT  = 14'h5;
    localparam csr_addr_t CSR_ERA    = 14'h6;
    localparam csr_addr_t CSR_BADV   = 14'h7;
    localparam csr_addr_t CSR_EENTRY = 14'hc;
    localparam csr_addr_t CSR_CPUID  = 14'h20;
    localparam csr_addr_t CSR_SAVE0  = 14'h30;
    localparam csr_addr_t CSR_SAVE1  = 14'h31;
    localparam csr_addr_t CSR_SAVE2  = 14'h32;
    localparam csr_addr_t CSR_SAVE3  = 14'h33;
    localparam csr_addr_t CSR_TID    = 14'h40;
    localparam csr_addr_t CSR_TCFG   = 14'h41;
    localparam csr_addr_t CSR_TVAL   = 14'h42;
    localparam csr_addr_t CSR_TICLR  = 14'h44;

    // crmd fields
    localparam int CRMD_PLV_LSB  = 0;
    localparam int CRMD_PLV_MSB  = 1;
    localparam int CRMD_IE       = 2;
    localparam int CRMD_DA       = 3;
    localparam int CRMD_PG       = 4;
    localparam int CRMD_DATF_LSB = 5;
    localparam int CRMD_DATF_MSB = 6;
    localparam int CRMD_DATM_LSB = 7;
    localparam int CRMD_DATM_MSB = 8;

    // prmd fields
    localparam int PRMD_PPLV_LSB = 0;
    localparam int PRMD_PPLV_MSB = 1;
    localparam int PRMD_PIE      = 2;

    // shared by ectl.lie and estat.is
    localparam int INT_LSB = 0;
    localparam int INT_MSB = 12;

    localparam int ESTAT_SWI_MSB      = 1;
    localparam int ESTAT_HWI_LSB      = 2;
    localparam int ESTAT_HWI_MSB      = 10;
    localparam int ESTAT_ECODE_LSB    = 16;
    localparam int ESTAT_ECODE_MSB    = 21;
    localparam int ESTAT_ESUBCODE_LSB = 22;
    localparam int ESTAT_ESUBCODE_MSB = 30;

    localparam int TCFG_EN          = 0;
    localparam int TCFG_PERIODIC    = 1;
    localparam int TCFG_INITVAL_LSB = 2;
    localparam int TCFG_INITVAL_MSB = 31;

    localparam int TICLR_CLR = 0;

    localparam int EENTRY_VA_LSB = 6;
    localparam int EENTRY_VA_MSB = 31;

    localparam int TIMER_IRQ_BIT = 11;

    typedef struct packed {
        logic      we;
        csr_addr_t addr;
        csr_word_t data;
    } csr_write_t;

    typedef struct packed {
        logic       excp_flush;
        logic       ertn_flush;
        logic [5:0] ecode;
        logic [8:0] esubcode;
        csr_word_t  era;
    } excp_event_t;

    typedef struct packed {
        logic      valid;
        csr_word_t addr;
    } va_fault_t;

    typedef struct packed {
        csr_word_t crmd;
        csr_word_t prmd;
        csr_word_t ectl;
        csr_word_t estat;
        csr_word_t era;
        csr_word_t badv;
        csr_word_t eentry;
    } exc_view_t;

    typedef struct packed {
        csr_word_t tcfg;
        csr_word_t tval;
    } timer_view_t;

    typedef struct packed {
        csr_word_t save0;
        csr_word_t save1;
        csr_word_t save2;
        csr_word_t save3;
        csr_word_t tid;
    } scratch_view_t;

endpackage
